// ==== logic/dma_cfg_pkg.sv ====
package dma_cfg_pkg;

	////////////////////////////////////////////////////////////
	// bus and requester sizes
	////////////////////////////////////////////////////////////
	localparam int WORD_W = 128;
	localparam int PORT_COUNT = 4; // fpu requesters on the token ring

	typedef logic [WORD_W-1:0] word_t; // one bus word
	typedef logic [39:0] dram_addr_t;
	typedef logic [15:0] dpram_addr_t;
	typedef logic [15:0] length_t; // word count, header included
	typedef logic [$clog2(PORT_COUNT)-1:0] port_id_t;

	// buffer depths
	localparam int STAGE_DEPTH = 256; // staging and write data
	localparam int CMD_DEPTH = 32; // command and order queues

endpackage

// ==== logic/dma_command_decoder.sv ====
module dma_command_decoder (
	input logic fpu_clk,
	input logic reset,
	input dma_cfg_pkg::word_t stage_data,
	input logic stage_empty,
	input dma_cfg_pkg::port_id_t order_id,
	input logic order_empty,
	input logic rd_cmd_full,
	input logic wr_cmd_full,
	input logic wr_data_full,
	output logic stage_pop,
	output logic order_pop,
	output logic rd_cmd_push,
	output logic wr_cmd_push,
	output dma_msg_pkg::dma_cmd_t cmd_data,
	output logic wr_data_push
);
	import dma_cfg_pkg::*;
	import dma_msg_pkg::*;

	// dpram bits below the requester index and the two cleared bits
	localparam int KEEP_W = $bits(dpram_addr_t) - $bits(port_id_t) - 2;

	typedef enum logic [1:0] {D_HEAD, D_DATA, D_WCMD, D_RCMD} dec_state_t;

	dec_state_t state;
	msg_form_t hdr_form;
	length_t hdr_len;
	length_t remain; // write words still to move
	logic hdr_take;
	logic move;

	assign hdr_form = stage_data[FORM_LSB +: $bits(msg_form_t)];
	assign hdr_len = stage_data[LEN_LSB +: $bits(length_t)];
	assign hdr_take = (state == D_HEAD) && !stage_empty && !order_empty;
	assign move = (state == D_DATA) && !stage_empty && !wr_data_full;

	assign stage_pop = hdr_take || move;
	assign order_pop = hdr_take; // index travels with its header
	assign wr_data_push = move;
	assign wr_cmd_push = (state == D_WCMD) && !wr_cmd_full;
	assign rd_cmd_push = (state == D_RCMD) && !rd_cmd_full;

	always_ff @(posedge fpu_clk) begin
		if (hdr_take) begin
			cmd_data.length <= hdr_len;
			cmd_data.dram_addr <= stage_data[DRAM_LSB +: $bits(dram_addr_t)];
			cmd_data.dpram_addr <= {order_id, 2'b00, stage_data[DPRAM_LSB +: KEEP_W]};
		end
	end

	////////////////////////////////////////////////////////////
	// message sequencing
	////////////////////////////////////////////////////////////
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= D_HEAD;
			remain <= '0;
		end else begin
			case (state)
				D_HEAD: begin
					if (hdr_take) begin
						remain <= hdr_len - 1'b1;
						if (hdr_form == MSG_WRITE && hdr_len > length_t'(1)) state <= D_DATA;
						else if (hdr_form == MSG_READ) state <= D_RCMD;
						// anything else carries no command
					end
				end
				D_DATA: begin
					if (move) begin
						remain <= remain - 1'b1;
						if (remain == length_t'(1)) state <= D_WCMD; // command after its data
					end
				end
				D_WCMD: begin
					if (!wr_cmd_full) state <= D_HEAD;
				end
				default: begin
					if (!rd_cmd_full) state <= D_HEAD;
				end
			endcase
		end
	end

	// a served index is recorded only after its header was staged
	assert property (@(posedge fpu_clk) disable iff (reset)
		state == D_HEAD && !order_empty |-> !stage_empty);

endmodule

// ==== logic/dma_msg_pkg.sv ====
package dma_msg_pkg;

	////////////////////////////////////////////////////////////
	// header word layout
	////////////////////////////////////////////////////////////
	localparam int FORM_LSB = 72; // 8 bit message form
	localparam int LEN_LSB = 56; // 16 bit word length
	localparam int DRAM_LSB = 16; // 40 bit dram address
	localparam int DPRAM_LSB = 0; // 16 bit dpram address

	typedef logic [7:0] msg_form_t;

	localparam msg_form_t MSG_READ = 8'h01;
	localparam msg_form_t MSG_WRITE = 8'h03;

	// dram side command, 72 bits
	typedef struct packed {
		dma_cfg_pkg::length_t length;
		dma_cfg_pkg::dram_addr_t dram_addr;
		dma_cfg_pkg::dpram_addr_t dpram_addr;
	} dma_cmd_t;

endpackage

// ==== logic/dma_path_top.sv ====
module dma_path_top #(
	parameter int STAGE_DEPTH = dma_cfg_pkg::STAGE_DEPTH
) (
	input logic fpu_clk,
	input logic reset,
	// fpu requesters
	input logic [dma_cfg_pkg::PORT_COUNT-1:0] dma_req,
	output logic [dma_cfg_pkg::PORT_COUNT-1:0] dma_resp,
	input logic [dma_cfg_pkg::PORT_COUNT-1:0] dma_write_valid,
	input dma_cfg_pkg::word_t [dma_cfg_pkg::PORT_COUNT-1:0] dma_write_data,
	output logic [dma_cfg_pkg::PORT_COUNT-1:0] dma_write_ready,
	// dram read commands
	output dma_cfg_pkg::dram_addr_t rcc_dram_addr,
	output dma_cfg_pkg::dpram_addr_t rcc_dpram_addr,
	output dma_cfg_pkg::length_t rcc_length,
	input logic rcc_ready,
	output logic rcc_valid,
	// dram write bursts
	output dma_cfg_pkg::dram_addr_t wcc_dram_addr,
	output dma_cfg_pkg::dpram_addr_t wcc_dpram_addr,
	output dma_cfg_pkg::length_t wcc_length,
	output dma_cfg_pkg::word_t wcc_write_data,
	input logic wcc_ready,
	output logic wcc_valid
);
	import dma_cfg_pkg::*;
	import dma_msg_pkg::*;

	logic grant_valid;
	port_id_t grant_id;
	logic burst_done;
	logic stage_push;
	word_t stage_wdata;
	logic stage_full;
	logic stage_pop;
	word_t stage_rdata;
	logic stage_empty;
	logic order_push;
	port_id_t order_wid;
	logic order_full;
	logic order_pop;
	port_id_t order_rid;
	logic order_empty;
	dma_cmd_t cmd_data; // shared by both command queues
	logic rd_cmd_push;
	logic rd_cmd_full;
	logic rd_cmd_pop;
	dma_cmd_t rd_cmd;
	logic rd_cmd_empty;
	logic wr_cmd_push;
	logic wr_cmd_full;
	logic wr_cmd_pop;
	dma_cmd_t wr_cmd;
	logic wr_cmd_empty;
	logic wr_data_push;
	logic wr_data_full;
	logic wr_data_pop;
	word_t wr_data;
	logic wr_data_empty;

	////////////////////////////////////////////////////////////
	// fpu side
	////////////////////////////////////////////////////////////
	dma_token_arbiter u_arbiter (
		.fpu_clk, .reset, .dma_req, .burst_done, .order_full, .grant_valid, .grant_id,
		.order_push, .order_id(order_wid)
	);

	fpu_write_capture u_capture (
		.fpu_clk, .reset, .grant_valid, .grant_id, .dma_write_valid, .dma_write_data,
		.stage_full, .dma_resp, .dma_write_ready, .stage_push, .stage_data(stage_wdata),
		.burst_done
	);

	sync_fifo #(.item_t(word_t), .DEPTH(STAGE_DEPTH)) u_stage_fifo (
		.fpu_clk, .reset, .push(stage_push), .push_data(stage_wdata), .pop(stage_pop),
		.pop_data(stage_rdata), .full(stage_full), .empty(stage_empty)
	);

	sync_fifo #(.item_t(port_id_t), .DEPTH(CMD_DEPTH)) u_order_fifo (
		.fpu_clk, .reset, .push(order_push), .push_data(order_wid), .pop(order_pop),
		.pop_data(order_rid), .full(order_full), .empty(order_empty)
	);

	dma_command_decoder u_decoder (
		.fpu_clk, .reset, .stage_data(stage_rdata), .stage_empty, .order_id(order_rid),
		.order_empty, .rd_cmd_full, .wr_cmd_full, .wr_data_full, .stage_pop, .order_pop,
		.rd_cmd_push, .wr_cmd_push, .cmd_data, .wr_data_push
	);

	////////////////////////////////////////////////////////////
	// dram side
	////////////////////////////////////////////////////////////
	sync_fifo #(.item_t(dma_cmd_t), .DEPTH(CMD_DEPTH)) u_rd_cmd_fifo (
		.fpu_clk, .reset, .push(rd_cmd_push), .push_data(cmd_data), .pop(rd_cmd_pop),
		.pop_data(rd_cmd), .full(rd_cmd_full), .empty(rd_cmd_empty)
	);

	sync_fifo #(.item_t(dma_cmd_t), .DEPTH(CMD_DEPTH)) u_wr_cmd_fifo (
		.fpu_clk, .reset, .push(wr_cmd_push), .push_data(cmd_data), .pop(wr_cmd_pop),
		.pop_data(wr_cmd), .full(wr_cmd_full), .empty(wr_cmd_empty)
	);

	sync_fifo #(.item_t(word_t), .DEPTH(STAGE_DEPTH)) u_wr_data_fifo (
		.fpu_clk, .reset, .push(wr_data_push), .push_data(stage_rdata), .pop(wr_data_pop),
		.pop_data(wr_data), .full(wr_data_full), .empty(wr_data_empty)
	);

	dram_command_issuer u_issuer (
		.fpu_clk, .reset, .rd_cmd, .rd_cmd_empty, .wr_cmd, .wr_cmd_empty, .wr_data,
		.wr_data_empty, .rcc_ready, .wcc_ready, .rd_cmd_pop, .wr_cmd_pop, .wr_data_pop,
		.rcc_valid, .rcc_dram_addr, .rcc_dpram_addr, .rcc_length, .wcc_valid,
		.wcc_dram_addr, .wcc_dpram_addr, .wcc_length, .wcc_write_data
	);

endmodule

// ==== logic/dma_token_arbiter.sv ====
module dma_token_arbiter (
	input logic fpu_clk,
	input logic reset,
	input logic [dma_cfg_pkg::PORT_COUNT-1:0] dma_req,
	input logic burst_done,
	input logic order_full,
	output logic grant_valid,
	output dma_cfg_pkg::port_id_t grant_id,
	output logic order_push,
	output dma_cfg_pkg::port_id_t order_id
);
	import dma_cfg_pkg::*;

	port_id_t last_id; // last requester served
	port_id_t next_id;
	logic record_pend; // served index waiting for the order queue

	// first requester after last_id, wrapping around
	always_comb begin
		port_id_t cand;
		next_id = last_id;
		for (int i = PORT_COUNT; i >= 1; i--) begin
			cand = port_id_t'(last_id + i);
			if (dma_req[cand]) begin
				next_id = cand; // nearest one wins
			end
		end
	end

	assign order_push = record_pend && !order_full;
	assign order_id = last_id;

	////////////////////////////////////////////////////////////
	// token state
	////////////////////////////////////////////////////////////
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			grant_valid <= 1'b0;
			grant_id <= '0;
			last_id <= port_id_t'(PORT_COUNT - 1); // so requester 0 goes first
			record_pend <= 1'b0;
		end else if (record_pend) begin
			if (!order_full) begin
				record_pend <= 1'b0;
			end
		end else if (grant_valid) begin
			if (burst_done) begin
				grant_valid <= 1'b0;
				last_id <= grant_id;
				record_pend <= 1'b1;
			end
		end else if (|dma_req) begin
			grant_valid <= 1'b1;
			grant_id <= next_id;
		end
	end

	// token held on one requester for the whole burst
	assert property (@(posedge fpu_clk) disable iff (reset)
		grant_valid && !burst_done |=> grant_valid && $stable(grant_id));

endmodule

// ==== logic/dram_command_issuer.sv ====
module dram_command_issuer (
	input logic fpu_clk,
	input logic reset,
	input dma_msg_pkg::dma_cmd_t rd_cmd,
	input logic rd_cmd_empty,
	input dma_msg_pkg::dma_cmd_t wr_cmd,
	input logic wr_cmd_empty,
	input dma_cfg_pkg::word_t wr_data,
	input logic wr_data_empty,
	input logic rcc_ready,
	input logic wcc_ready,
	output logic rd_cmd_pop,
	output logic wr_cmd_pop,
	output logic wr_data_pop,
	output logic rcc_valid,
	output dma_cfg_pkg::dram_addr_t rcc_dram_addr,
	output dma_cfg_pkg::dpram_addr_t rcc_dpram_addr,
	output dma_cfg_pkg::length_t rcc_length,
	output logic wcc_valid,
	output dma_cfg_pkg::dram_addr_t wcc_dram_addr,
	output dma_cfg_pkg::dpram_addr_t wcc_dpram_addr,
	output dma_cfg_pkg::length_t wcc_length,
	output dma_cfg_pkg::word_t wcc_write_data
);
	import dma_cfg_pkg::*;
	import dma_msg_pkg::*;

	dma_cmd_t wr_q; // command of the burst in flight
	length_t words_left;
	logic wr_start;

	// read commands go straight out of the queue
	assign rcc_valid = !rd_cmd_empty && rcc_ready;
	assign rd_cmd_pop = rcc_valid;
	assign rcc_dram_addr = rd_cmd.dram_addr;
	assign rcc_dpram_addr = rd_cmd.dpram_addr;
	assign rcc_length = rd_cmd.length;

	////////////////////////////////////////////////////////////
	// write burst
	////////////////////////////////////////////////////////////
	assign wr_start = !wcc_valid && !wr_cmd_empty && !wr_data_empty && wcc_ready;
	assign wr_cmd_pop = wr_start;
	assign wr_data_pop = wcc_valid && wcc_ready;
	assign wcc_dram_addr = wr_q.dram_addr;
	assign wcc_dpram_addr = wr_q.dpram_addr;
	assign wcc_length = wr_q.length;
	assign wcc_write_data = wr_data; // show-ahead head word

	always_ff @(posedge fpu_clk) begin
		if (wr_start) begin
			wr_q <= wr_cmd;
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wcc_valid <= 1'b0;
			words_left <= '0;
		end else if (wr_start) begin
			wcc_valid <= 1'b1;
			words_left <= wr_cmd.length - 1'b1; // header not sent
		end else if (wr_data_pop) begin
			words_left <= words_left - 1'b1;
			if (words_left == length_t'(1)) wcc_valid <= 1'b0;
		end
	end

endmodule

// ==== logic/fpu_write_capture.sv ====
module fpu_write_capture (
	input logic fpu_clk,
	input logic reset,
	input logic grant_valid,
	input dma_cfg_pkg::port_id_t grant_id,
	input logic [dma_cfg_pkg::PORT_COUNT-1:0] dma_write_valid,
	input dma_cfg_pkg::word_t [dma_cfg_pkg::PORT_COUNT-1:0] dma_write_data,
	input logic stage_full,
	output logic [dma_cfg_pkg::PORT_COUNT-1:0] dma_resp,
	output logic [dma_cfg_pkg::PORT_COUNT-1:0] dma_write_ready,
	output logic stage_push,
	output dma_cfg_pkg::word_t stage_data,
	output logic burst_done
);
	import dma_cfg_pkg::*;
	import dma_msg_pkg::*;

	typedef enum logic [1:0] {C_IDLE, C_HEAD, C_BODY, C_DONE} cap_state_t;

	cap_state_t state;
	length_t burst_len;
	length_t word_cnt; // words taken so far, header included
	msg_form_t hdr_form;
	length_t hdr_len;
	logic burst_open;
	logic take;

	// granted requester only
	assign stage_data = dma_write_data[grant_id];
	assign burst_open = (state == C_HEAD) || (state == C_BODY);
	assign take = burst_open && dma_write_valid[grant_id] && !stage_full;
	assign stage_push = take;
	assign burst_done = (state == C_DONE);

	assign hdr_form = stage_data[FORM_LSB +: $bits(msg_form_t)];
	assign hdr_len = stage_data[LEN_LSB +: $bits(length_t)];

	always_comb begin
		dma_resp = '0;
		dma_write_ready = '0;
		dma_resp[grant_id] = (state == C_HEAD); // until header is taken
		dma_write_ready[grant_id] = burst_open && !stage_full;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= C_IDLE;
			burst_len <= '0;
			word_cnt <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					if (grant_valid) state <= C_HEAD;
				end
				C_HEAD: begin
					if (take) begin
						word_cnt <= length_t'(1);
						burst_len <= hdr_len;
						// reads and short writes end with the header
						if (hdr_form == MSG_WRITE && hdr_len > length_t'(1)) state <= C_BODY;
						else state <= C_DONE;
					end
				end
				C_BODY: begin
					if (take) begin
						word_cnt <= word_cnt + 1'b1;
						if (word_cnt + 1'b1 == burst_len) state <= C_DONE;
					end
				end
				default: state <= C_IDLE; // burst_done strobe
			endcase
		end
	end

endmodule

// ==== logic/sync_fifo.sv ====
module sync_fifo #(
	parameter type item_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input logic fpu_clk,
	input logic reset,
	input logic push,
	input item_t push_data,
	input logic pop,
	output item_t pop_data,
	output logic full,
	output logic empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign pop_data = mem[rd_ptr]; // show-ahead
	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	always_ff @(posedge fpu_clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// neighbours must respect full and empty
	assert property (@(posedge fpu_clk) disable iff (reset) !(push && full));
	assert property (@(posedge fpu_clk) disable iff (reset) !(pop && empty));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the DMA path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dma_path -f sim.f \
	-o tb_dma_path > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_dma_path > sim.log 2>&1
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== sim.f ====
logic/dma_cfg_pkg.sv
logic/dma_msg_pkg.sv
logic/sync_fifo.sv
logic/dma_token_arbiter.sv
logic/fpu_write_capture.sv
logic/dma_command_decoder.sv
logic/dram_command_issuer.sv
logic/dma_path_top.sv
test/tb_dma_path.sv

// ==== test/dma_stimulus.txt ====
# requester form length dram_addr dpram_addr stall, all hex
# stall 1 holds the dram ready low at random while that message drains
0 03 5 0000100000 f010 0
1 03 4 0000200040 3123 0
2 01 6 0000300080 c200 0
3 03 3 00004000c0 0abc 1
0 01 8 0000500100 ffff 0
1 03 9 0000600140 5a5a 1
2 03 2 0000700180 0001 0
3 01 1 00008001c0 8765 0
1 01 4 0000900200 1234 1
2 03 7 0000a00240 e00e 1
0 03 6 0000b00280 7ff0 1
3 03 4 0000c002c0 4321 0

// ==== test/tb_dma_path.sv ====
module tb_dma_path;
	import dma_cfg_pkg::*;
	import dma_msg_pkg::*;

	localparam int MAX_MSG = 64;
	localparam int MAX_WORDS = 1024;
	localparam int WAIT_LIMIT = 4000; // cycles per handshake wait
	localparam int RUN_LIMIT = 40000; // cycles for the dram side to drain

	logic fpu_clk;
	logic reset;
	logic [PORT_COUNT-1:0] dma_req;
	logic [PORT_COUNT-1:0] dma_resp;
	logic [PORT_COUNT-1:0] dma_write_valid;
	word_t [PORT_COUNT-1:0] dma_write_data;
	logic [PORT_COUNT-1:0] dma_write_ready;
	dram_addr_t rcc_dram_addr;
	dpram_addr_t rcc_dpram_addr;
	length_t rcc_length;
	logic rcc_ready;
	logic rcc_valid;
	dram_addr_t wcc_dram_addr;
	dpram_addr_t wcc_dpram_addr;
	length_t wcc_length;
	word_t wcc_write_data;
	logic wcc_ready;
	logic wcc_valid;

	// per requester drive, one process each
	logic req_bit [PORT_COUNT];
	logic valid_bit [PORT_COUNT];
	word_t data_word [PORT_COUNT];

	// message table from the stimulus file
	port_id_t msg_port [MAX_MSG];
	msg_form_t msg_form [MAX_MSG];
	length_t msg_len [MAX_MSG];
	dram_addr_t msg_dram [MAX_MSG];
	dpram_addr_t msg_dpram [MAX_MSG];
	logic msg_stall [MAX_MSG];
	int msg_base [MAX_MSG]; // first data word in data_mem
	int msg_count;
	word_t data_mem [MAX_WORDS];
	int word_total;
	int exp_rcc [$]; // message indices in expected order
	int exp_wcc [$];
	port_id_t exp_grant [$]; // requesters in expected grant order
	logic [15:0] lfsr;

	for (genvar g = 0; g < PORT_COUNT; g++) begin : g_port
		assign dma_req[g] = req_bit[g];
		assign dma_write_valid[g] = valid_bit[g];
		assign dma_write_data[g] = data_word[g];
	end

	dma_path_top #(.STAGE_DEPTH(STAGE_DEPTH)) u_dut (
		.fpu_clk, .reset, .dma_req, .dma_resp, .dma_write_valid, .dma_write_data,
		.dma_write_ready, .rcc_dram_addr, .rcc_dpram_addr, .rcc_length, .rcc_ready,
		.rcc_valid, .wcc_dram_addr, .wcc_dpram_addr, .wcc_length, .wcc_write_data,
		.wcc_ready, .wcc_valid
	);

	always #2 fpu_clk = ~fpu_clk;

	////////////////////////////////////////////////////////////
	// error reporting
	////////////////////////////////////////////////////////////
	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %0t: %s", $time, what);
		stop_with_failure();
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// 16 bit fibonacci, taps 16 14 13 11
	function automatic logic take_bit();
		lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		return lfsr[0];
	endfunction

	function automatic word_t random_word();
		word_t w;
		for (int b = 0; b < WORD_W; b++) begin
			w[b] = take_bit();
		end
		return w;
	endfunction

	function automatic word_t make_header(input int m);
		word_t h;
		h = '0;
		h[FORM_LSB +: 8] = msg_form[m];
		h[LEN_LSB +: 16] = msg_len[m];
		h[DRAM_LSB +: 40] = msg_dram[m];
		h[DPRAM_LSB +: 16] = msg_dpram[m];
		return h;
	endfunction

	function automatic logic is_long_write(input int m);
		return msg_form[m] == MSG_WRITE && msg_len[m] > 16'd1;
	endfunction

	// requester index on top, two cleared bits below it
	function automatic dpram_addr_t expected_dpram(input int m);
		return {msg_port[m], 2'b00, msg_dpram[m][11:0]};
	endfunction

	task automatic load_stimulus();
		int fd;
		int code;
		string line;
		int f_port;
		int f_form;
		int f_len;
		logic [63:0] f_dram;
		int f_dpram;
		int f_stall;
		fd = $fopen("test/dma_stimulus.txt", "r");
		if (fd == 0) report_problem("cannot open test/dma_stimulus.txt");
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23 && msg_count < MAX_MSG) begin
				code = $sscanf(line, "%h %h %h %h %h %h", f_port, f_form, f_len, f_dram,
					f_dpram, f_stall);
				if (code == 6) begin
					msg_port[msg_count] = port_id_t'(f_port);
					msg_form[msg_count] = msg_form_t'(f_form);
					msg_len[msg_count] = length_t'(f_len);
					msg_dram[msg_count] = f_dram[39:0];
					msg_dpram[msg_count] = dpram_addr_t'(f_dpram);
					msg_stall[msg_count] = (f_stall != 0);
					msg_base[msg_count] = word_total;
					if (is_long_write(msg_count)) begin
						for (int k = 1; k < int'(msg_len[msg_count]); k++) begin
							data_mem[word_total] = random_word();
							word_total++;
						end
					end
					msg_count++;
				end
			end
		end
		$fclose(fd);
	endtask

	// token walks round the ring over requesters that still have messages
	task automatic build_expected();
		int done_cnt [PORT_COUNT];
		port_id_t last;
		port_id_t cand;
		logic found;
		int seen;
		for (int p = 0; p < PORT_COUNT; p++) done_cnt[p] = 0;
		last = port_id_t'(PORT_COUNT - 1);
		for (int placed = 0; placed < msg_count; placed++) begin
			found = 1'b0;
			for (int step = 1; step <= PORT_COUNT; step++) begin
				if (!found) begin
					cand = port_id_t'(int'(last) + step);
					seen = 0;
					for (int m = 0; m < msg_count; m++) begin
						if (msg_port[m] == cand) begin
							if (seen == done_cnt[cand] && !found) begin
								found = 1'b1;
								if (msg_form[m] == MSG_READ) exp_rcc.push_back(m);
								else if (is_long_write(m)) exp_wcc.push_back(m);
							end
							seen++;
						end
					end
				end
			end
			done_cnt[cand]++;
			exp_grant.push_back(cand);
			last = cand;
		end
	endtask

	////////////////////////////////////////////////////////////
	// requester side
	////////////////////////////////////////////////////////////
	task automatic send_messages(input int id);
		int limit;
		int nwords;
		int left;
		left = 0;
		for (int m = 0; m < msg_count; m++) begin
			if (msg_port[m] == port_id_t'(id)) left++;
		end
		for (int m = 0; m < msg_count; m++) begin
			if (msg_port[m] == port_id_t'(id)) begin
				limit = 0;
				while (!dma_resp[id]) begin // token and resp
					@(negedge fpu_clk);
					limit++;
					if (limit > WAIT_LIMIT) report_problem("timeout waiting for dma_resp");
				end
				nwords = is_long_write(m) ? int'(msg_len[m]) : 1;
				for (int k = 0; k < nwords; k++) begin
					valid_bit[id] = 1'b1;
					data_word[id] = (k == 0) ? make_header(m) : data_mem[msg_base[m] + k - 1];
					limit = 0;
					while (!dma_write_ready[id]) begin
						@(negedge fpu_clk);
						limit++;
						if (limit > WAIT_LIMIT) report_problem("timeout waiting for dma_write_ready");
					end
					@(negedge fpu_clk); // word taken on the rising edge
				end
				valid_bit[id] = 1'b0;
				void'(exp_grant.pop_front());
				left--;
				if (left == 0) req_bit[id] = 1'b0;
			end
		end
	endtask

	task automatic check_requester_outputs();
		assert ($countones(dma_resp | dma_write_ready) <= 1) else
			report_problem("more than one requester sees dma_resp or dma_write_ready");
		for (int i = 0; i < PORT_COUNT; i++) begin
			if (dma_resp[i] || dma_write_ready[i]) begin
				assert (exp_grant.size() > 0 && exp_grant[0] == port_id_t'(i)) else
					report_problem("dma_resp or dma_write_ready high for a requester not granted");
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// dram side
	////////////////////////////////////////////////////////////
	task automatic watch_dram();
		int m;
		int wcc_idx;
		logic burst_ended;
		wcc_idx = 0;
		burst_ended = 1'b0;
		forever begin
			@(negedge fpu_clk);
			rcc_ready = (exp_rcc.size() > 0 && msg_stall[exp_rcc[0]]) ? take_bit() : 1'b1;
			wcc_ready = (exp_wcc.size() > 0 && msg_stall[exp_wcc[0]]) ? take_bit() : 1'b1;
			#1;
			check_requester_outputs();
			if (burst_ended) begin
				assert (!wcc_valid) else report_problem("wcc_valid stayed high after a burst");
				burst_ended = 1'b0;
			end
			if (rcc_valid) begin
				assert (exp_rcc.size() > 0) else report_problem("read command nobody asked for");
				m = exp_rcc.pop_front();
				check_value("rcc_dram_addr", 128'(rcc_dram_addr), 128'(msg_dram[m]));
				check_value("rcc_dpram_addr", 128'(rcc_dpram_addr), 128'(expected_dpram(m)));
				check_value("rcc_length", 128'(rcc_length), 128'(msg_len[m]));
			end
			if (wcc_valid) begin
				assert (exp_wcc.size() > 0) else report_problem("write burst nobody asked for");
			end
			if (wcc_valid && wcc_ready) begin
				m = exp_wcc[0];
				check_value("wcc_dram_addr", 128'(wcc_dram_addr), 128'(msg_dram[m]));
				check_value("wcc_dpram_addr", 128'(wcc_dpram_addr), 128'(expected_dpram(m)));
				check_value("wcc_length", 128'(wcc_length), 128'(msg_len[m]));
				check_value("wcc_write_data", wcc_write_data, data_mem[msg_base[m] + wcc_idx]);
				wcc_idx++;
				if (wcc_idx == int'(msg_len[m]) - 1) begin
					void'(exp_wcc.pop_front());
					wcc_idx = 0;
					burst_ended = 1'b1;
				end
			end
		end
	endtask

	initial begin
		int limit;
		fpu_clk = 1'b0;
		reset = 1'b1;
		rcc_ready = 1'b0;
		wcc_ready = 1'b0;
		for (int i = 0; i < PORT_COUNT; i++) begin
			req_bit[i] = 1'b0;
			valid_bit[i] = 1'b0;
			data_word[i] = '0;
		end
		lfsr = 16'd36288;
		msg_count = 0;
		word_total = 0;
		load_stimulus();
		if (msg_count == 0) report_problem("stimulus file holds no messages");
		build_expected();
		repeat (16) @(posedge fpu_clk);
		@(negedge fpu_clk);
		reset = 1'b0;
		#1;
		check_value("dma_resp", 128'(dma_resp), 128'(0));
		check_value("dma_write_ready", 128'(dma_write_ready), 128'(0));
		check_value("rcc_valid", 128'(rcc_valid), 128'(0));
		check_value("wcc_valid", 128'(wcc_valid), 128'(0));
		@(negedge fpu_clk);
		for (int m = 0; m < msg_count; m++) req_bit[msg_port[m]] = 1'b1; // all at once
		fork
			watch_dram();
		join_none
		fork
			send_messages(0);
			send_messages(1);
			send_messages(2);
			send_messages(3);
		join
		limit = 0;
		while (exp_rcc.size() > 0 || exp_wcc.size() > 0 || wcc_valid) begin
			@(negedge fpu_clk);
			limit++;
			if (limit > RUN_LIMIT) report_problem("timeout waiting for the dram side to drain");
		end
		repeat (4) @(negedge fpu_clk);
		$display("Done: no errors");
		$finish;
	end

endmodule
